/* logic/vdpPkg.sv */
package vdpPkg;

	localparam int FRAC_BITS       = 10;
	localparam int CMD_STRIDE      = 16;
	localparam int CMD_FETCH_WORDS = 7;

	typedef logic signed [10:0] coord_t;
	typedef logic signed [20:0] fixed_t;
	typedef logic [15:0]        color_t;
	typedef logic [17:0]        vramAddr_t;
	typedef logic [16:0]        fbAddr_t;
	typedef logic [3:0]         regAddr_t;
	typedef logic [15:0]        regData_t;

	// Unit step of the DDA
	localparam fixed_t FIXED_ONE = fixed_t'(1 << FRAC_BITS);

	typedef struct packed {
		logic       endBit;
		logic       skip;
		logic [1:0] jumpMode;
		logic [7:0] spare;
		logic [3:0] code;
	} cmdCtrl_t;

	typedef struct packed {
		cmdCtrl_t    ctrl;
		logic [15:0] link;
		logic [15:0] pmod;
		color_t      colr;
		coord_t      xa;
		coord_t      ya;
		coord_t      xb;
		coord_t      yb;
		coord_t      xc;
		coord_t      yc;
	} command_t;

	localparam logic [3:0] COMM_LINE      = 4'h6;
	localparam logic [3:0] COMM_USER_CLIP = 4'h8;
	localparam logic [3:0] COMM_SYS_CLIP  = 4'h9;
	localparam logic [3:0] COMM_LOCAL     = 4'hA;

	localparam logic [1:0] JUMP_NEXT   = 2'd0;
	localparam logic [1:0] JUMP_ASSIGN = 2'd1;
	localparam logic [1:0] JUMP_CALL   = 2'd2;
	localparam logic [1:0] JUMP_RETURN = 2'd3;

	localparam int PMOD_USER_CLIP_BIT = 9;
	localparam int SYS_CLIP_X2_RESET  = 319;
	localparam int SYS_CLIP_Y2_RESET  = 255;

	localparam regAddr_t REG_FBCR = 4'd1;
	localparam regAddr_t REG_PTMR = 4'd2;
	localparam regAddr_t REG_EDSR = 4'd8;
	localparam regAddr_t REG_LOPR = 4'd9;
	localparam regAddr_t REG_COPR = 4'd10;

	localparam int FBCR_FCT = 0;
	localparam int FBCR_FCM = 1;

	localparam logic [1:0] PTM_NOW  = 2'd1;
	localparam logic [1:0] PTM_AUTO = 2'd2;

endpackage

/* logic/vdpRegs.sv */
module vdpRegs (
	input  logic              CLK,
	input  logic              RST_N,
	input  vdpPkg::regAddr_t  regAddr,
	input  vdpPkg::regData_t  regWData,
	input  logic              regWe,
	input  logic              regRe,
	output vdpPkg::regData_t  regRData,
	input  logic              vtimN,
	input  logic              listEnd,
	input  vdpPkg::vramAddr_t cmdAddr,
	output logic              drawStart,
	output logic              drawBank,
	output logic              irqN
);
	logic [1:0]        fbcr;
	logic [1:0]        ptm;
	logic              changeReq;
	logic              curEnd;
	logic              prevEnd;
	logic              vtimOld;
	logic [15:0]       lopr;
	logic [15:0]       copr;
	vdpPkg::vramAddr_t lastAddr;
	logic              fbcrWrite;
	logic              ptmrWrite;
	logic              frameEdge;
	logic              frameAccept;
	logic              addrMoved;

	assign fbcrWrite = regWe && (regAddr == vdpPkg::REG_FBCR);
	assign ptmrWrite = regWe && (regAddr == vdpPkg::REG_PTMR);
	assign frameEdge = vtimN && !vtimOld;
	// Manual mode needs FCT plus a pending request
	assign frameAccept = frameEdge &&
		(!fbcr[vdpPkg::FBCR_FCM] || (fbcr[vdpPkg::FBCR_FCT] && changeReq));
	// Sequencer moves cmdAddr only when a new fetch begins
	assign addrMoved = cmdAddr != lastAddr;
	assign irqN = !curEnd;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			fbcr      <= '0;
			ptm       <= '0;
			changeReq <= 1'b0;
			curEnd    <= 1'b0;
			prevEnd   <= 1'b0;
			vtimOld   <= 1'b1;
			drawBank  <= 1'b1;
			drawStart <= 1'b0;
			lastAddr  <= '0;
			lopr      <= '0;
			copr      <= '0;
			regRData  <= '0;
		end else begin
			vtimOld   <= vtimN;
			lastAddr  <= cmdAddr;
			drawStart <= (ptmrWrite && regWData[1:0] == vdpPkg::PTM_NOW) ||
				(frameAccept && ptm == vdpPkg::PTM_AUTO);

			if (frameAccept) begin
				drawBank  <= !drawBank;
				prevEnd   <= curEnd;
				curEnd    <= 1'b0;
				changeReq <= 1'b0;
			end
			if (listEnd)
				curEnd <= 1'b1;

			if (fbcrWrite) begin
				fbcr <= regWData[1:0];
				if (regWData[vdpPkg::FBCR_FCT])
					changeReq <= 1'b1;
			end
			if (ptmrWrite)
				ptm <= regWData[1:0];

			if (listEnd || addrMoved) begin
				lopr <= copr;
				copr <= cmdAddr[17:2];
			end

			if (regRe) begin
				case (regAddr)
					vdpPkg::REG_EDSR: regRData <= {14'd0, curEnd, prevEnd};
					vdpPkg::REG_LOPR: regRData <= lopr;
					vdpPkg::REG_COPR: regRData <= copr;
					default:          regRData <= '0;
				endcase
			end
		end
	end

	// PTMR write and frame change must not land on adjacent cycles
	drawStartSingle: assert property (@(posedge CLK) disable iff (!RST_N)
		drawStart |=> !drawStart);

endmodule

/* logic/cmdSequencer.sv */
module cmdSequencer (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              drawStart,
	output vdpPkg::vramAddr_t vramA,
	output logic              vramRd,
	input  logic              vramReady,
	input  logic [31:0]       vramQ,
	output logic              lineStart,
	output vdpPkg::command_t  cmd,
	input  logic              lineDone,
	output logic              setUserClip,
	output logic              setSysClip,
	output logic              setLocal,
	output vdpPkg::vramAddr_t cmdAddr,
	output logic              listEnd
);
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_FETCH,
		SEQ_EXEC,
		SEQ_LINE,
		SEQ_NEXT
	} seqState_t;

	seqState_t         state;
	logic [2:0]        fetchCnt;
	logic              discard;
	vdpPkg::vramAddr_t retAddr;
	vdpPkg::vramAddr_t nextAddr;

	assign nextAddr = cmdAddr + vdpPkg::vramAddr_t'(vdpPkg::CMD_STRIDE);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state       <= SEQ_IDLE;
			fetchCnt    <= '0;
			discard     <= 1'b0;
			vramA       <= '0;
			vramRd      <= 1'b0;
			cmdAddr     <= '0;
			retAddr     <= '0;
			lineStart   <= 1'b0;
			setUserClip <= 1'b0;
			setSysClip  <= 1'b0;
			setLocal    <= 1'b0;
			listEnd     <= 1'b0;
		end else begin
			lineStart   <= 1'b0;
			setUserClip <= 1'b0;
			setSysClip  <= 1'b0;
			setLocal    <= 1'b0;
			listEnd     <= 1'b0;
			if (drawStart) begin
				cmdAddr  <= '0;
				fetchCnt <= '0;
				state    <= SEQ_FETCH;
				// A read still in flight belongs to the old walk
				discard  <= vramRd && !vramReady;
				if (vramReady)
					vramRd <= 1'b0;
			end else begin
				case (state)
					SEQ_FETCH: begin
						if (!vramRd) begin
							vramA  <= cmdAddr + vdpPkg::vramAddr_t'({fetchCnt, 1'b0});
							vramRd <= 1'b1;
						end else if (vramReady) begin
							vramRd <= 1'b0;
							if (discard) begin
								discard <= 1'b0;
							end else begin
								fetchCnt <= fetchCnt + 3'd1;
								if (fetchCnt == 3'(vdpPkg::CMD_FETCH_WORDS - 1))
									state <= SEQ_EXEC;
							end
						end
					end
					SEQ_EXEC: begin
						fetchCnt <= '0;
						state    <= SEQ_NEXT;
						if (cmd.ctrl.endBit) begin
							listEnd <= 1'b1;
							state   <= SEQ_IDLE;
						end else if (!cmd.ctrl.skip) begin
							case (cmd.ctrl.code)
								vdpPkg::COMM_LINE: begin
									lineStart <= 1'b1;
									state     <= SEQ_LINE;
								end
								vdpPkg::COMM_USER_CLIP: setUserClip <= 1'b1;
								vdpPkg::COMM_SYS_CLIP:  setSysClip <= 1'b1;
								vdpPkg::COMM_LOCAL:     setLocal <= 1'b1;
								default: ;
							endcase
						end
					end
					SEQ_LINE: begin
						if (lineDone)
							state <= SEQ_NEXT;
					end
					SEQ_NEXT: begin
						case (cmd.ctrl.jumpMode)
							vdpPkg::JUMP_NEXT:   cmdAddr <= nextAddr;
							vdpPkg::JUMP_ASSIGN: cmdAddr <= {cmd.link, 2'b00};
							vdpPkg::JUMP_CALL: begin
								cmdAddr <= {cmd.link, 2'b00};
								retAddr <= nextAddr;
							end
							vdpPkg::JUMP_RETURN: cmdAddr <= retAddr;
						endcase
						state <= SEQ_FETCH;
					end
					default: ;
				endcase
			end
		end
	end

	// Word pairs arrive with the lower address in the upper half
	always_ff @(posedge CLK) begin
		if (vramRd && vramReady && !discard) begin
			case (fetchCnt)
				3'd0: begin
					cmd.ctrl <= vramQ[31:16];
					cmd.link <= vramQ[15:0];
				end
				3'd1: begin
					cmd.pmod <= vramQ[31:16];
					cmd.colr <= vramQ[15:0];
				end
				3'd3: begin
					cmd.xa <= vramQ[26:16];
					cmd.ya <= vramQ[10:0];
				end
				3'd4: begin
					cmd.xb <= vramQ[26:16];
					cmd.yb <= vramQ[10:0];
				end
				3'd5: begin
					cmd.xc <= vramQ[26:16];
					cmd.yc <= vramQ[10:0];
				end
				default: ;
			endcase
		end
	end

	// Ready only answers an outstanding read
	vramReadyOnRead: assert property (@(posedge CLK) disable iff (!RST_N)
		vramReady |-> vramRd);

endmodule

/* logic/lineEngine.sv */
module lineEngine (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic             lineStart,
	input  vdpPkg::command_t cmd,
	output logic             lineDone,
	output logic             divStart,
	output vdpPkg::coord_t   divNum,
	output vdpPkg::coord_t   divDen,
	input  logic             divDone,
	input  vdpPkg::fixed_t   divQuot,
	output logic             pixelValid,
	output vdpPkg::coord_t   pixelX,
	output vdpPkg::coord_t   pixelY
);
	typedef enum logic [2:0] {
		LN_IDLE,
		LN_SETUP,
		LN_DIV,
		LN_DRAW,
		LN_DONE
	} lineState_t;

	lineState_t     state;
	vdpPkg::coord_t deltaX;
	vdpPkg::coord_t deltaY;
	vdpPkg::coord_t originX;
	vdpPkg::coord_t originY;
	vdpPkg::coord_t absX;
	vdpPkg::coord_t absY;
	vdpPkg::coord_t majorLen;
	vdpPkg::coord_t minorLen;
	vdpPkg::coord_t count;
	logic           dirX;
	logic           dirY;
	logic           xMajor;
	vdpPkg::fixed_t accX;
	vdpPkg::fixed_t accY;
	vdpPkg::fixed_t stepX;
	vdpPkg::fixed_t stepY;

	assign deltaX   = cmd.xb - cmd.xa;
	assign deltaY   = cmd.yb - cmd.ya;
	assign xMajor   = absX >= absY;
	assign majorLen = xMajor ? absX : absY;
	assign minorLen = xMajor ? absY : absX;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state      <= LN_IDLE;
			lineDone   <= 1'b0;
			divStart   <= 1'b0;
			pixelValid <= 1'b0;
		end else begin
			lineDone   <= 1'b0;
			divStart   <= 1'b0;
			pixelValid <= 1'b0;
			case (state)
				LN_IDLE: begin
					if (lineStart)
						state <= LN_SETUP;
				end
				LN_SETUP: begin
					// Axis-aligned and single-point lines skip the divider
					if (minorLen != '0) begin
						divStart <= 1'b1;
						state    <= LN_DIV;
					end else begin
						state <= LN_DRAW;
					end
				end
				LN_DIV: begin
					if (divDone)
						state <= LN_DRAW;
				end
				LN_DRAW: begin
					pixelValid <= 1'b1;
					if (count == majorLen)
						state <= LN_DONE;
				end
				LN_DONE: begin
					lineDone <= 1'b1;
					state    <= LN_IDLE;
				end
				default: state <= LN_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		case (state)
			LN_IDLE: begin
				if (lineStart) begin
					originX <= cmd.xa;
					originY <= cmd.ya;
					dirX    <= !deltaX[10];
					dirY    <= !deltaY[10];
					absX    <= deltaX[10] ? -deltaX : deltaX;
					absY    <= deltaY[10] ? -deltaY : deltaY;
				end
			end
			LN_SETUP: begin
				count  <= '0;
				accX   <= '0;
				accY   <= '0;
				divNum <= minorLen;
				divDen <= majorLen;
				stepX  <= '0;
				stepY  <= '0;
				if (xMajor)
					stepX <= dirX ? vdpPkg::FIXED_ONE : -vdpPkg::FIXED_ONE;
				else
					stepY <= dirY ? vdpPkg::FIXED_ONE : -vdpPkg::FIXED_ONE;
			end
			LN_DIV: begin
				if (divDone) begin
					if (xMajor)
						stepY <= dirY ? divQuot : -divQuot;
					else
						stepX <= dirX ? divQuot : -divQuot;
				end
			end
			LN_DRAW: begin
				// Truncating the fraction floors toward minus infinity
				pixelX <= originX + accX[20:vdpPkg::FRAC_BITS];
				pixelY <= originY + accY[20:vdpPkg::FRAC_BITS];
				accX   <= accX + stepX;
				accY   <= accY + stepY;
				count  <= count + 11'sd1;
			end
			default: ;
		endcase
	end

endmodule

/* logic/slopeDivider.sv */
module slopeDivider (
	input  logic           CLK,
	input  logic           RST_N,
	input  logic           divStart,
	input  vdpPkg::coord_t divNum,
	input  vdpPkg::coord_t divDen,
	output logic           divDone,
	output vdpPkg::fixed_t divQuot
);
	logic        busy;
	logic [4:0]  stepCnt;
	logic [10:0] rem;
	logic [10:0] remIn;
	logic [10:0] remNext;
	logic [11:0] trial;
	logic [20:0] work;
	logic [20:0] workIn;
	logic [10:0] den;
	logic [10:0] denIn;
	logic        fits;

	// First quotient bit is taken in the start cycle itself
	always_comb begin
		remIn   = divStart ? '0 : rem;
		workIn  = divStart ? {divNum, {vdpPkg::FRAC_BITS{1'b0}}} : work;
		denIn   = divStart ? divDen : den;
		trial   = {remIn, workIn[20]};
		fits    = trial >= {1'b0, denIn};
		remNext = fits ? 11'(trial - {1'b0, denIn}) : trial[10:0];
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			busy    <= 1'b0;
			stepCnt <= '0;
			divDone <= 1'b0;
		end else begin
			divDone <= 1'b0;
			if (divStart) begin
				busy    <= 1'b1;
				stepCnt <= 5'd1;
			end else if (busy) begin
				stepCnt <= stepCnt + 5'd1;
				if (stepCnt == 5'($bits(vdpPkg::fixed_t) - 1)) begin
					busy    <= 1'b0;
					divDone <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (divStart || busy) begin
			rem  <= remNext;
			work <= {workIn[19:0], fits};
			den  <= denIn;
		end
	end

	assign divQuot = work;

	denNonZero: assert property (@(posedge CLK) disable iff (!RST_N)
		divStart |-> divDen != '0);

endmodule

/* logic/pixelWriter.sv */
module pixelWriter (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic             pixelValid,
	input  vdpPkg::coord_t   pixelX,
	input  vdpPkg::coord_t   pixelY,
	input  vdpPkg::command_t cmd,
	input  logic             setUserClip,
	input  logic             setSysClip,
	input  logic             setLocal,
	output logic             fbWe,
	output vdpPkg::fbAddr_t  fbA,
	output vdpPkg::color_t   fbD
);
	vdpPkg::coord_t userX1;
	vdpPkg::coord_t userY1;
	vdpPkg::coord_t userX2;
	vdpPkg::coord_t userY2;
	vdpPkg::coord_t sysX2;
	vdpPkg::coord_t sysY2;
	vdpPkg::coord_t locX;
	vdpPkg::coord_t locY;
	vdpPkg::coord_t drawX;
	vdpPkg::coord_t drawY;
	logic           inSys;
	logic           inUser;
	logic           userClipOn;

	assign drawX      = pixelX + locX;
	assign drawY      = pixelY + locY;
	assign inSys      = drawX >= 0 && drawY >= 0 && drawX <= sysX2 && drawY <= sysY2;
	// User rectangle is inclusive on all four edges
	assign inUser     = drawX >= userX1 && drawX <= userX2 &&
		drawY >= userY1 && drawY <= userY2;
	assign userClipOn = cmd.pmod[vdpPkg::PMOD_USER_CLIP_BIT];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			userX1 <= '0;
			userY1 <= '0;
			userX2 <= '0;
			userY2 <= '0;
			sysX2  <= vdpPkg::coord_t'(vdpPkg::SYS_CLIP_X2_RESET);
			sysY2  <= vdpPkg::coord_t'(vdpPkg::SYS_CLIP_Y2_RESET);
			locX   <= '0;
			locY   <= '0;
			fbWe   <= 1'b0;
		end else begin
			if (setUserClip) begin
				userX1 <= cmd.xa;
				userY1 <= cmd.ya;
				userX2 <= cmd.xc;
				userY2 <= cmd.yc;
			end
			if (setSysClip) begin
				sysX2 <= cmd.xc;
				sysY2 <= cmd.yc;
			end
			if (setLocal) begin
				locX <= cmd.xa;
				locY <= cmd.ya;
			end
			fbWe <= pixelValid && inSys && (inUser || !userClipOn);
		end
	end

	always_ff @(posedge CLK) begin
		if (pixelValid) begin
			fbA <= {drawY[7:0], drawX[8:0]};
			fbD <= cmd.colr;
		end
	end

endmodule

/* logic/vdpCore.sv */
module vdpCore (
	input  logic              CLK,
	input  logic              RST_N,
	input  vdpPkg::regAddr_t  regAddr,
	input  vdpPkg::regData_t  regWData,
	input  logic              regWe,
	input  logic              regRe,
	output vdpPkg::regData_t  regRData,
	input  logic              vtimN,
	output logic              drawBank,
	output logic              irqN,
	output vdpPkg::vramAddr_t vramA,
	output logic              vramRd,
	input  logic              vramReady,
	input  logic [31:0]       vramQ,
	output logic              fbWe,
	output vdpPkg::fbAddr_t   fbA,
	output vdpPkg::color_t    fbD
);
	logic              drawStart;
	logic              listEnd;
	vdpPkg::vramAddr_t cmdAddr;
	logic              lineStart;
	logic              lineDone;
	vdpPkg::command_t  cmd;
	logic              setUserClip;
	logic              setSysClip;
	logic              setLocal;
	logic              divStart;
	vdpPkg::coord_t    divNum;
	vdpPkg::coord_t    divDen;
	logic              divDone;
	vdpPkg::fixed_t    divQuot;
	logic              pixelValid;
	vdpPkg::coord_t    pixelX;
	vdpPkg::coord_t    pixelY;

	vdpRegs u_vdpRegs (
		.CLK(CLK), .RST_N(RST_N),
		.regAddr(regAddr), .regWData(regWData), .regWe(regWe), .regRe(regRe),
		.regRData(regRData), .vtimN(vtimN), .listEnd(listEnd), .cmdAddr(cmdAddr),
		.drawStart(drawStart), .drawBank(drawBank), .irqN(irqN)
	);

	cmdSequencer u_cmdSequencer (
		.CLK(CLK), .RST_N(RST_N), .drawStart(drawStart),
		.vramA(vramA), .vramRd(vramRd), .vramReady(vramReady), .vramQ(vramQ),
		.lineStart(lineStart), .cmd(cmd), .lineDone(lineDone),
		.setUserClip(setUserClip), .setSysClip(setSysClip), .setLocal(setLocal),
		.cmdAddr(cmdAddr), .listEnd(listEnd)
	);

	lineEngine u_lineEngine (
		.CLK(CLK), .RST_N(RST_N), .lineStart(lineStart), .cmd(cmd),
		.lineDone(lineDone), .divStart(divStart), .divNum(divNum), .divDen(divDen),
		.divDone(divDone), .divQuot(divQuot),
		.pixelValid(pixelValid), .pixelX(pixelX), .pixelY(pixelY)
	);

	slopeDivider u_slopeDivider (
		.CLK(CLK), .RST_N(RST_N), .divStart(divStart), .divNum(divNum),
		.divDen(divDen), .divDone(divDone), .divQuot(divQuot)
	);

	pixelWriter u_pixelWriter (
		.CLK(CLK), .RST_N(RST_N), .pixelValid(pixelValid),
		.pixelX(pixelX), .pixelY(pixelY), .cmd(cmd),
		.setUserClip(setUserClip), .setSysClip(setSysClip), .setLocal(setLocal),
		.fbWe(fbWe), .fbA(fbA), .fbD(fbD)
	);

endmodule

/* tests/vdpCore_tb.sv */
module vdpCore_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 4000;

	logic              CLK;
	logic              RST_N;
	vdpPkg::regAddr_t  regAddr;
	vdpPkg::regData_t  regWData;
	logic              regWe;
	logic              regRe;
	vdpPkg::regData_t  regRData;
	logic              vtimN;
	logic              drawBank;
	logic              irqN;
	vdpPkg::vramAddr_t vramA;
	logic              vramRd;
	logic              vramReady = 1'b0;
	logic [31:0]       vramQ = '0;
	logic              fbWe;
	vdpPkg::fbAddr_t   fbA;
	vdpPkg::color_t    fbD;

	logic [15:0] vram [0:4095];
	logic [32:0] pixQ [$];
	logic        vramBusy = 1'b0;
	int          vramDelay = 0;
	integer      seed;
	string       testName;
	int          testCount;
	int          checkCount;
	int          errorCount;
	int          testErrors;
	bit          timedOut;

	vdpCore u_vdpCore (
		.CLK(CLK), .RST_N(RST_N),
		.regAddr(regAddr), .regWData(regWData), .regWe(regWe), .regRe(regRe),
		.regRData(regRData), .vtimN(vtimN), .drawBank(drawBank), .irqN(irqN),
		.vramA(vramA), .vramRd(vramRd), .vramReady(vramReady), .vramQ(vramQ),
		.fbWe(fbWe), .fbA(fbA), .fbD(fbD)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = !CLK;
	end

	// Framebuffer writes in arrival order
	always @(negedge CLK) begin
		if (fbWe === 1'b1)
			pixQ.push_back({fbA, fbD});
	end

	// VRAM answers each read after 1 to 4 cycles
	always @(negedge CLK) begin
		vramReady <= 1'b0;
		if (!RST_N) begin
			vramBusy <= 1'b0;
		end else if (vramBusy) begin
			if (vramDelay <= 1) begin
				vramReady <= 1'b1;
				vramQ     <= {vram[vramA[11:0]], vram[vramA[11:0] + 12'd1]};
				vramBusy  <= 1'b0;
			end else begin
				vramDelay <= vramDelay - 1;
			end
		end else if (vramRd && !vramReady) begin
			vramBusy  <= 1'b1;
			vramDelay <= 1 + ($random(seed) & 3);
		end
	end

	task automatic noteError();
		errorCount++;
		testErrors++;
	endtask

	task automatic reportTimeout(input string what);
		$display("timeout in test %s while waiting for %s", testName, what);
		noteError();
		timedOut = 1'b1;
	endtask

	task automatic writeReg(input vdpPkg::regAddr_t a, input vdpPkg::regData_t d);
		regAddr  = a;
		regWData = d;
		regWe    = 1'b1;
		@(negedge CLK);
		regWe = 1'b0;
		@(negedge CLK);
	endtask

	task automatic pulseVtim();
		vtimN = 1'b1;
		repeat (2) @(negedge CLK);
		vtimN = 1'b0;
		repeat (2) @(negedge CLK);
	endtask

	// Words 4 and 5 of a command are never used
	task automatic loadCommand(input int base, input int w [11]);
		vram[base]      = 16'(w[1]);
		vram[base + 1]  = 16'(w[2]);
		vram[base + 2]  = 16'(w[3]);
		vram[base + 3]  = 16'(w[4]);
		for (int k = 0; k < 6; k++)
			vram[base + 6 + k] = 16'(w[5 + k]);
	endtask

	task automatic waitListEnd();
		int   n;
		logic done;
		n       = 0;
		done    = 1'b0;
		regAddr = vdpPkg::REG_EDSR;
		while (!done && n < WAIT_LIMIT) begin
			regRe = 1'b1;
			@(negedge CLK);
			regRe = 1'b0;
			// Current end flag is bit 1 of EDSR
			done = regRData[1] === 1'b1;
			@(negedge CLK);
			n++;
		end
		if (!done)
			reportTimeout("the end flag at the end of the list");
	endtask

	task automatic checkPixel(input vdpPkg::fbAddr_t expA, input vdpPkg::color_t expD);
		int          n;
		logic [32:0] got;
		n = 0;
		while (pixQ.size() == 0 && n < WAIT_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		checkCount++;
		if (pixQ.size() == 0) begin
			reportTimeout("a framebuffer write");
			return;
		end
		got = pixQ.pop_front();
		if (got !== {expA, expD}) begin
			$display("FAILED %s: pixel expected %05h/%04h actual %05h/%04h",
				testName, expA, expD, got[32:16], got[15:0]);
			noteError();
		end
	endtask

	task automatic checkReg(input vdpPkg::regAddr_t a, input vdpPkg::regData_t expD);
		vdpPkg::regData_t got;
		regAddr = a;
		regRe   = 1'b1;
		@(negedge CLK);
		regRe = 1'b0;
		got   = regRData;
		checkCount++;
		if (got !== expD) begin
			$display("FAILED %s: register %0h expected %04h actual %04h",
				testName, a, expD, got);
			noteError();
		end
	endtask

	task automatic checkLevel(input string what, input logic expL, input logic actL);
		checkCount++;
		if (actL !== expL) begin
			$display("FAILED %s: %s expected %b actual %b", testName, what, expL, actL);
			noteError();
		end
	endtask

	task automatic finishTest();
		if (testName == "")
			return;
		if (pixQ.size() != 0) begin
			$display("test %s wrote %0d pixels that were not expected", testName, pixQ.size());
			noteError();
			pixQ.delete();
		end
		if (testErrors == 0)
			$display("test %s: ok", testName);
		else
			$display("test %s: %0d errors", testName, testErrors);
	endtask

	initial begin
		int    fd;
		int    code;
		int    v0;
		int    v1;
		int    w [11];
		string tok;
		string rest;
		seed       = 32'h9e10;
		testName   = "";
		testCount  = 0;
		checkCount = 0;
		errorCount = 0;
		testErrors = 0;
		timedOut   = 1'b0;
		RST_N      = 1'b0;
		regAddr    = '0;
		regWData   = '0;
		regWe      = 1'b0;
		regRe      = 1'b0;
		vtimN      = 1'b0;
		for (int i = 0; i < 4096; i++)
			vram[i] = 16'((i * 257) ^ 16'hA5C3);
		fd = $fopen("tests/stim_lines.txt", "r");
		if (fd == 0) begin
			$display("stimulus file tests/stim_lines.txt could not be opened");
			errorCount++;
		end
		repeat (2) @(negedge CLK);
		RST_N = 1'b1;
		@(negedge CLK);

		while (fd != 0 && !timedOut) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1)
				break;
			if (tok.substr(0, 0) == "#") begin
				code = $fgets(rest, fd);
			end else if (tok == "M") begin
				for (int k = 0; k < 11; k++)
					code = $fscanf(fd, "%h", w[k]);
				loadCommand(w[0], w);
			end else if (tok == "W") begin
				code = $fscanf(fd, "%h %h", v0, v1);
				writeReg(vdpPkg::regAddr_t'(v0), vdpPkg::regData_t'(v1));
			end else if (tok == "V") begin
				pulseVtim();
			end else if (tok == "T") begin
				finishTest();
				code = $fscanf(fd, "%s", testName);
				testErrors = 0;
				testCount++;
			end else if (tok == "P") begin
				code = $fscanf(fd, "%h %h", v0, v1);
				checkPixel(vdpPkg::fbAddr_t'(v0), vdpPkg::color_t'(v1));
			end else if (tok == "R") begin
				code = $fscanf(fd, "%h %h", v0, v1);
				checkReg(vdpPkg::regAddr_t'(v0), vdpPkg::regData_t'(v1));
			end else if (tok == "I") begin
				code = $fscanf(fd, "%h", v0);
				checkLevel("irqN", v0[0], irqN);
			end else if (tok == "B") begin
				code = $fscanf(fd, "%h", v0);
				checkLevel("drawBank", v0[0], drawBank);
			end else if (tok == "D") begin
				waitListEnd();
			end else begin
				$display("unknown record %s in the stimulus file", tok);
				noteError();
			end
		end
		finishTest();
		if (fd != 0)
			$fclose(fd);

		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* tests/stim_lines.txt */
# M addr ctrl link pmod colr xa ya xb yb xc yc | W reg data | V vtimN pulse | T name
# P fbAddr colour | R reg data | I irqN | B drawBank | D wait for list end (all hex)
T octants
M 0000 0006 0000 0000 1111 000A 000A 000D 000B 0000 0000
M 0010 0006 0000 0000 2222 0014 0014 0013 0011 0000 0000
M 0020 0006 0000 0000 3333 0005 0006 0005 0006 0000 0000
M 0030 0006 0000 0000 4444 001E 0005 001C 0006 0000 0000
M 0040 8000 0000 0000 0000 0000 0000 0000 0000 0000 0000
W 2 0001
P 140A 1111
P 140B 1111
P 140C 1111
P 140D 1111
P 2814 2222
P 2613 2222
P 2413 2222
P 2213 2222
P 0C05 3333
P 0A1E 4444
P 0A1D 4444
P 0C1C 4444
D
I 0
R 8 0002
T userClip
M 0000 0008 0000 0000 0000 0002 0002 0000 0000 0004 0004
M 0010 0006 0000 0200 7777 0000 0003 0006 0003 0000 0000
M 0020 0006 0000 0000 8888 0000 0005 0001 0005 0000 0000
M 0030 8000 0000 0000 0000 0000 0000 0000 0000 0000 0000
V
W 2 0001
P 0602 7777
P 0603 7777
P 0604 7777
P 0A00 8888
P 0A01 8888
D
T listWalk
M 0000 4006 0000 0000 9999 0001 0001 0001 0001 0000 0000
M 0010 2006 0010 0000 AAAA 0002 0000 0002 0000 0000 0000
M 0020 1006 0018 0000 BBBB 0003 0000 0003 0000 0000 0000
M 0030 0006 0000 0000 CCCC 0004 0000 0004 0000 0000 0000
M 0040 3006 0000 0000 DDDD 0005 0000 0005 0000 0000 0000
M 0060 8000 0000 0000 0000 0000 0000 0000 0000 0000 0000
V
W 2 0001
P 0002 AAAA
P 0005 DDDD
P 0003 BBBB
D
R 9 0018
R A 0018
T localSysClip
M 0000 0009 0000 0000 0000 0000 0000 0000 0000 0066 003C
M 0010 000A 0000 0000 0000 0064 0032 0000 0000 0000 0000
M 0020 0006 0000 0000 5555 0000 0000 0004 0000 0000 0000
M 0030 0006 0000 0000 6666 FF9B FFCD FF9D FFCF 0000 0000
M 0040 8000 0000 0000 0000 0000 0000 0000 0000 0000 0000
V
W 2 0001
P 6464 5555
P 6465 5555
P 6466 5555
P 0000 6666
P 0201 6666
D
I 0
R 8 0003
T autoFrame
V
I 1
B 1
R 8 0001
T manualFrame
W 1 0002
V
B 1
W 2 0002
W 1 0003
V
P 6464 5555
P 6465 5555
P 6466 5555
P 0000 6666
P 0201 6666
D
B 0
R 8 0002

/* flist.f */
logic/vdpPkg.sv
logic/vdpRegs.sv
logic/cmdSequencer.sv
logic/lineEngine.sv
logic/slopeDivider.sv
logic/pixelWriter.sv
logic/vdpCore.sv
tests/vdpCore_tb.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module vdpCore_tb -f flist.f
	@out="$$(./obj_dir/VvdpCore_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

lint:
	verilator --lint-only --timing --top-module vdpCore_tb -f flist.f

clean:
	rm -rf obj_dir
